//--- sources.f
rtl/usb_tx_pkg.sv
rtl/usb_crc16.sv
rtl/ulpi_skid_loader.sv
rtl/ulpi_encoder.sv
rtl/phy_init_sequencer.sv
rtl/ulpi_link_tx.sv
testbench/ulpi_link_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module ulpi_link_tx_tb \
  -f sources.f -o ulpi_link_tx_sim \
  && ./obj_dir/ulpi_link_tx_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/ulpi_link_tx_tb.sv
`timescale 1ns/1ns
module ulpi_link_tx_tb;

  localparam int N_PKT = 5;

  logic       clock;
  logic       reset;
  logic [1:0] line_state_i;
  logic       hsk_send_i;
  logic       s_valid_i;
  logic       s_keep_i;
  logic       s_last_i;
  logic [3:0] s_pid_i;
  logic [7:0] s_data_i;
  logic       ulpi_dir_i;
  logic       ulpi_nxt_i;
  logic       s_ready_o;
  logic       usb_busy_o;
  logic       usb_done_o;
  logic       init_done_o;
  logic       ulpi_stp_o;
  logic [7:0] ulpi_data_o;

  // Packet table with stimulus and expected bus byte count
  string      tbl_name    [N_PKT];
  logic [3:0] tbl_pid     [N_PKT];
  int         tbl_len     [N_PKT];
  logic       tbl_hsk     [N_PKT];
  int         tbl_exp_len [N_PKT];
  logic [7:0] tbl_data    [N_PKT][8];

  // PHY model state
  logic [31:0] lfsr_q = 32'h906d;
  logic        nxt_a;
  logic        nxt_b;
  int          se0_left;
  logic        tx_active;
  logic        stp_prev;
  logic [7:0]  cap_q[$];
  int          stp_count;
  int          stp_len;
  int          done_count;

  // Bookkeeping
  int cycle_count;
  int cycle_limit;
  int value_errors;
  int proto_errors;
  int cap_base;
  int stp_base;

  ulpi_link_tx dut0 (
    .clock        (clock),
    .reset        (reset),
    .line_state_i (line_state_i),
    .hsk_send_i   (hsk_send_i),
    .s_valid_i    (s_valid_i),
    .s_keep_i     (s_keep_i),
    .s_last_i     (s_last_i),
    .s_pid_i      (s_pid_i),
    .s_data_i     (s_data_i),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .s_ready_o    (s_ready_o),
    .usb_busy_o   (usb_busy_o),
    .usb_done_o   (usb_done_o),
    .init_done_o  (init_done_o),
    .ulpi_stp_o   (ulpi_stp_o),
    .ulpi_data_o  (ulpi_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and the new bit entering at the LSB
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Wire form of the CRC is bit reversed and complemented
  function automatic logic [15:0] crc_wire(input logic [15:0] residue);
    logic [15:0] r;
    for (int i = 0; i < 16; i++) begin
      r[i] = ~residue[15-i];
    end
    return r;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input usb_tx_pkg::tx_state_t exp,
                             input usb_tx_pkg::tx_state_t act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic fill_table();
    tbl_name[0] = "data0_3";
    tbl_pid[0] = usb_tx_pkg::PID_DATA0;
    tbl_len[0] = 3;
    tbl_hsk[0] = 1'b0;
    tbl_exp_len[0] = 6;
    tbl_data[0] = '{8'h12, 8'h34, 8'h56, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    // Zero-length packet carries only the CRC
    tbl_name[1] = "data1_zlp";
    tbl_pid[1] = usb_tx_pkg::PID_DATA1;
    tbl_len[1] = 0;
    tbl_hsk[1] = 1'b0;
    tbl_exp_len[1] = 3;
    tbl_data[1] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    tbl_name[2] = "ack_hsk";
    tbl_pid[2] = usb_tx_pkg::PID_ACK;
    tbl_len[2] = 0;
    tbl_hsk[2] = 1'b1;
    tbl_exp_len[2] = 1;
    tbl_data[2] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    // Zero bytes inside a packet must not be taken for idle
    tbl_name[3] = "data1_8";
    tbl_pid[3] = usb_tx_pkg::PID_DATA1;
    tbl_len[3] = 8;
    tbl_hsk[3] = 1'b0;
    tbl_exp_len[3] = 11;
    tbl_data[3] = '{8'h00, 8'hff, 8'h5a, 8'ha5, 8'h01, 8'h80, 8'h7e, 8'hc3};
    tbl_name[4] = "nak_hsk";
    tbl_pid[4] = usb_tx_pkg::PID_NAK;
    tbl_len[4] = 0;
    tbl_hsk[4] = 1'b1;
    tbl_exp_len[4] = 1;
    tbl_data[4] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  endtask

  // PHY nxt takes two LFSR bits per cycle and is high about 3 cycles in 4
  always @(posedge clock) begin
    lfsr_q = lfsr_next(lfsr_q);
    nxt_a = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    nxt_b = lfsr_q[0];
    ulpi_nxt_i <= !(nxt_a && nxt_b);
  end

  // Line state goes to SE0 for two cycles after each stp and rests in J
  always @(posedge clock) begin
    if (ulpi_stp_o) begin
      line_state_i <= usb_tx_pkg::LS_SE0;
      se0_left <= 1;
    end else if (se0_left != 0) begin
      se0_left <= se0_left - 1;
    end else begin
      line_state_i <= 2'b01;
    end
  end

  // Bus capture where a non-zero byte opens a transfer and stp closes it
  always @(posedge clock) begin
    if (reset) begin
      tx_active = 1'b0;
      stp_prev = 1'b0;
    end else begin
      if (ulpi_stp_o) begin
        if (stp_prev) begin
          proto_errors++;
          $display("stp stayed high for more than one cycle");
        end
        stp_count++;
        stp_len = cap_q.size();
        tx_active = 1'b0;
      end else if ((tx_active || ulpi_data_o != 8'h00) && ulpi_nxt_i) begin
        cap_q.push_back(ulpi_data_o);
        tx_active = 1'b1;
      end
      stp_prev = ulpi_stp_o;
      if (usb_done_o) begin
        done_count++;
      end
    end
  end

  // Run limit
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic send_packet(input int p);
    int sent;
    int beats;
    sent = 0;
    beats = (tbl_len[p] == 0) ? 1 : tbl_len[p];
    @(posedge clock);
    s_pid_i <= tbl_pid[p];
    if (tbl_hsk[p]) begin
      // Hold the request until the encoder goes busy
      hsk_send_i <= 1'b1;
      do @(posedge clock); while (!usb_busy_o);
      hsk_send_i <= 1'b0;
    end else begin
      s_valid_i <= 1'b1;
      s_keep_i <= tbl_len[p] != 0;
      s_last_i <= beats == 1;
      s_data_i <= tbl_data[p][0];
      while (sent < beats) begin
        @(posedge clock);
        if (s_ready_o) begin
          sent++;
          if (sent == beats) begin
            s_valid_i <= 1'b0;
            s_last_i <= 1'b0;
          end else begin
            s_data_i <= tbl_data[p][sent];
            s_last_i <= sent == beats - 1;
          end
        end
      end
    end
  endtask

  // Expected bus bytes are the TX CMD, the payload and the CRC low byte then high
  task automatic check_packet(input int p);
    logic [7:0]  exp_q[$];
    logic [15:0] residue;
    logic [15:0] wire_crc;
    int          got;
    exp_q.push_back({usb_tx_pkg::ULPI_CMD_TX, 2'b00, tbl_pid[p]});
    if (!tbl_hsk[p]) begin
      residue = usb_tx_pkg::CRC16_INIT;
      for (int k = 0; k < tbl_len[p]; k++) begin
        exp_q.push_back(tbl_data[p][k]);
        residue = usb_tx_pkg::crc16_step(tbl_data[p][k], residue);
      end
      wire_crc = crc_wire(residue);
      exp_q.push_back(wire_crc[7:0]);
      exp_q.push_back(wire_crc[15:8]);
    end
    got = cap_q.size() - cap_base;
    check_count({tbl_name[p], " byte count"}, tbl_exp_len[p], got);
    for (int k = 0; k < exp_q.size() && k < got; k++) begin
      check_byte({tbl_name[p], " byte"}, exp_q[k], cap_q[cap_base + k]);
    end
    check_count({tbl_name[p], " stp count"}, 1, stp_count - stp_base);
    check_count({tbl_name[p], " stp position"}, tbl_exp_len[p], stp_len - cap_base);
    check_count({tbl_name[p], " done pulses"}, p + 1, done_count);
    check_state({tbl_name[p], " end state"}, usb_tx_pkg::TX_IDLE, dut0.enc_state);
  endtask

  initial begin
    logic [7:0] init_exp[5];
    reset = 1'b1;
    line_state_i = 2'b01;
    hsk_send_i = 1'b0;
    s_valid_i = 1'b0;
    s_keep_i = 1'b0;
    s_last_i = 1'b0;
    s_pid_i = 4'h0;
    s_data_i = 8'h00;
    ulpi_dir_i = 1'b0;
    ulpi_nxt_i = 1'b0;
    se0_left = 0;
    stp_count = 0;
    stp_len = 0;
    done_count = 0;
    cycle_count = 0;
    value_errors = 0;
    proto_errors = 0;
    fill_table();
    cycle_limit = 200;
    for (int i = 0; i < N_PKT; i++) begin
      cycle_limit += 40 * tbl_exp_len[i];
    end

    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_flag("reset stp", 1'b0, ulpi_stp_o);
    check_flag("reset s_ready", 1'b0, s_ready_o);
    check_flag("reset busy", 1'b0, usb_busy_o);
    check_flag("reset usb_done", 1'b0, usb_done_o);
    check_flag("reset init_done", 1'b0, init_done_o);
    check_state("reset state", usb_tx_pkg::TX_IDLE, dut0.enc_state);

    // Start-up sends two register writes and then NOPID
    while (!init_done_o) @(posedge clock);
    @(negedge clock);
    // Function control gets SuspendM with chirp OpMode and the HS transceiver
    // OTG control gets both pull-downs
    init_exp = '{{usb_tx_pkg::ULPI_CMD_REGW, 6'h04}, 8'h50,
                 {usb_tx_pkg::ULPI_CMD_REGW, 6'h0a}, 8'h06,
                 usb_tx_pkg::ULPI_NOPID};
    check_count("init byte count", 5, cap_q.size());
    for (int k = 0; k < 5 && k < cap_q.size(); k++) begin
      check_byte("init byte", init_exp[k], cap_q[k]);
    end
    check_count("init stp count", 3, stp_count);
    check_count("init done pulses", 0, done_count);

    for (int p = 0; p < N_PKT; p++) begin
      cap_base = cap_q.size();
      stp_base = stp_count;
      send_packet(p);
      do @(posedge clock); while (!usb_done_o);
      @(negedge clock);
      check_packet(p);
    end

    repeat (4) @(posedge clock);
    // No late done pulse or stp after the last packet
    check_count("final done pulses", N_PKT, done_count);
    check_count("final stp count", 3 + N_PKT, stp_count);
    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- rtl/ulpi_link_tx.sv
`timescale 1ns/1ns
module ulpi_link_tx (
  input  logic       clock,
  input  logic       reset,
  input  logic [1:0] line_state_i,
  input  logic       hsk_send_i,
  input  logic       s_valid_i,
  input  logic       s_keep_i,
  input  logic       s_last_i,
  input  logic [3:0] s_pid_i,
  input  logic [7:0] s_data_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic       s_ready_o,
  output logic       usb_busy_o,
  output logic       usb_done_o,
  output logic       init_done_o,
  output logic       ulpi_stp_o,
  output logic [7:0] ulpi_data_o
);

  // Sequencer to encoder requests
  logic       phy_write;
  logic       phy_nopid;
  logic [7:0] phy_addr;
  logic [7:0] phy_data;
  logic       phy_done;

  usb_tx_pkg::tx_state_t enc_state;

  phy_init_sequencer u_seq (
    .clock       (clock),
    .reset       (reset),
    .phy_done_i  (phy_done),
    .phy_write_o (phy_write),
    .phy_nopid_o (phy_nopid),
    .phy_addr_o  (phy_addr),
    .phy_data_o  (phy_data),
    .init_done_o (init_done_o)
  );

  // Packets only once the PHY is set up
  ulpi_encoder u_enc (
    .clock        (clock),
    .reset        (reset),
    .high_speed_i (init_done_o),
    .line_state_i (line_state_i),
    .phy_write_i  (phy_write),
    .phy_nopid_i  (phy_nopid),
    .phy_addr_i   (phy_addr),
    .phy_data_i   (phy_data),
    .hsk_send_i   (hsk_send_i),
    .s_valid_i    (s_valid_i),
    .s_keep_i     (s_keep_i),
    .s_last_i     (s_last_i),
    .s_pid_i      (s_pid_i),
    .s_data_i     (s_data_i),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .phy_done_o   (phy_done),
    .usb_busy_o   (usb_busy_o),
    .usb_done_o   (usb_done_o),
    .s_ready_o    (s_ready_o),
    .enc_state_o  (enc_state),
    .ulpi_stp_o   (ulpi_stp_o),
    .ulpi_data_o  (ulpi_data_o)
  );

  // No register traffic once start-up has finished
  a_no_regw_after_init: assert property (
    @(posedge clock) disable iff (reset)
    init_done_o |-> enc_state != usb_tx_pkg::TX_REGW && enc_state != usb_tx_pkg::TX_INIT
  );

endmodule

//--- rtl/phy_init_sequencer.sv
`timescale 1ns/1ns
module phy_init_sequencer (
  input  logic       clock,
  input  logic       reset,
  input  logic       phy_done_i,
  output logic       phy_write_o,
  output logic       phy_nopid_o,
  output logic [7:0] phy_addr_o,
  output logic [7:0] phy_data_o,
  output logic       init_done_o
);

  // Writes first, then the NOPID step, then done
  logic [usb_tx_pkg::INIT_STEP_W-1:0] step_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      step_q <= '0;
    end else if (phy_done_i && !init_done_o) begin
      step_q <= step_q + 1'b1;
    end
  end

  // Request is a level, held until the encoder answers
  assign phy_write_o = step_q < usb_tx_pkg::INIT_STEP_NOPID;
  assign phy_nopid_o = step_q == usb_tx_pkg::INIT_STEP_NOPID;
  assign init_done_o = step_q == usb_tx_pkg::INIT_STEP_DONE;

  // Table lookup for the current write
  assign phy_addr_o = usb_tx_pkg::init_addr(step_q);
  assign phy_data_o = usb_tx_pkg::init_data(step_q);

  // Encoder only answers an open request
  a_done_has_request: assert property (
    @(posedge clock) disable iff (reset)
    phy_done_i |-> phy_write_o || phy_nopid_o
  );

endmodule

//--- rtl/ulpi_encoder.sv
`timescale 1ns/1ns
module ulpi_encoder (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  high_speed_i,
  input  logic [1:0]            line_state_i,
  input  logic                  phy_write_i,
  input  logic                  phy_nopid_i,
  input  logic [7:0]            phy_addr_i,
  input  logic [7:0]            phy_data_i,
  input  logic                  hsk_send_i,
  input  logic                  s_valid_i,
  input  logic                  s_keep_i,
  input  logic                  s_last_i,
  input  logic [3:0]            s_pid_i,
  input  logic [7:0]            s_data_i,
  input  logic                  ulpi_dir_i,
  input  logic                  ulpi_nxt_i,
  output logic                  phy_done_o,
  output logic                  usb_busy_o,
  output logic                  usb_done_o,
  output logic                  s_ready_o,
  output usb_tx_pkg::tx_state_t enc_state_o,
  output logic                  ulpi_stp_o,
  output logic [7:0]            ulpi_data_o
);

  usb_tx_pkg::tx_state_t state_q;

  logic dir_q;
  logic frozen;
  logic phy_done_q;
  logic usb_done_q;

  // TX CMD byte carrying the PID
  logic [7:0] tx_cmd;

  // Loader channels
  logic       ld_s_valid;
  logic       ld_s_ready;
  logic       ld_s_last;
  logic [7:0] ld_s_data;
  logic       ld_t_valid;
  logic       ld_t_ready;
  logic       ld_t_last;
  logic [7:0] ld_t_data;
  logic       ld_m_valid;
  logic       ld_m_ready;
  logic       ld_m_last;
  logic [7:0] ld_m_data;

  logic        crc_clear;
  logic        crc_valid;
  logic [15:0] crc;

  // PHY owns the bus while dir is high, plus one turnaround cycle
  assign frozen = ulpi_dir_i || dir_q;

  assign tx_cmd = {usb_tx_pkg::ULPI_CMD_TX, 2'b00, s_pid_i};

  assign enc_state_o = state_q;
  assign usb_busy_o = state_q != usb_tx_pkg::TX_IDLE;
  assign phy_done_o = phy_done_q;
  assign usb_done_o = usb_done_q;

  assign ld_m_ready = ulpi_nxt_i && !frozen;
  assign ulpi_stp_o = ld_m_last;
  // NOOP (all zero) when nothing is queued
  assign ulpi_data_o = ld_m_valid ? ld_m_data : 8'h00;

  // CRC covers every kept byte taken from the source
  assign crc_clear = state_q == usb_tx_pkg::TX_IDLE;
  assign crc_valid = s_valid_i && s_ready_o && s_keep_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
    end
  end

  // Byte selection for the loader
  always_comb begin
    ld_s_valid = 1'b0;
    ld_s_last = 1'b0;
    ld_s_data = 8'h00;
    ld_t_valid = 1'b0;
    ld_t_last = 1'b0;
    ld_t_data = 8'h00;
    s_ready_o = 1'b0;
    if (!frozen) begin
      case (state_q)
        usb_tx_pkg::TX_XPID: begin
          // TX CMD, with the first byte or the stp marker behind it
          ld_s_valid = ld_t_ready && (hsk_send_i || s_valid_i);
          ld_s_data = tx_cmd;
          ld_t_valid = ld_t_ready && (hsk_send_i || s_valid_i && s_keep_i);
          ld_t_last = hsk_send_i;
          ld_t_data = hsk_send_i ? 8'h00 : s_data_i;
          s_ready_o = ld_t_ready && !hsk_send_i;
        end
        usb_tx_pkg::TX_DATA: begin
          // A beat with keep low only ends the packet
          ld_s_valid = s_valid_i && s_keep_i;
          ld_s_data = s_data_i;
          s_ready_o = ld_s_ready;
        end
        usb_tx_pkg::TX_CRC0: begin
          ld_s_valid = 1'b1;
          ld_s_data = crc[7:0];
        end
        usb_tx_pkg::TX_CRC1: begin
          ld_s_valid = 1'b1;
          ld_s_data = crc[15:8];
        end
        usb_tx_pkg::TX_LAST, usb_tx_pkg::TX_REGW: begin
          // stp marker
          ld_s_valid = 1'b1;
          ld_s_last = 1'b1;
        end
        usb_tx_pkg::TX_INIT: begin
          // Register write command plus value, or a bare NOPID
          ld_s_valid = ld_t_ready && (phy_write_i || phy_nopid_i);
          ld_s_data = phy_write_i ? {usb_tx_pkg::ULPI_CMD_REGW, phy_addr_i[5:0]} :
                                    usb_tx_pkg::ULPI_NOPID;
          ld_t_valid = ld_t_ready && phy_write_i;
          ld_t_data = phy_data_i;
        end
        default: begin
        end
      endcase
    end
  end

  // Transmit FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_tx_pkg::TX_IDLE;
      phy_done_q <= 1'b0;
      usb_done_q <= 1'b0;
    end else begin
      phy_done_q <= 1'b0;
      usb_done_q <= 1'b0;
      if (!frozen) begin
        case (state_q)
          usb_tx_pkg::TX_IDLE: begin
            if (!high_speed_i) begin
              // Skip the request just answered, it drops next cycle
              if ((phy_write_i || phy_nopid_i) && !phy_done_q) begin
                state_q <= usb_tx_pkg::TX_INIT;
              end
            end else if (hsk_send_i || s_valid_i) begin
              state_q <= usb_tx_pkg::TX_XPID;
            end
          end
          usb_tx_pkg::TX_XPID: begin
            if (ld_t_ready) begin
              if (hsk_send_i) begin
                state_q <= usb_tx_pkg::TX_STOP;
              end else if (s_valid_i) begin
                state_q <= s_keep_i && !s_last_i ? usb_tx_pkg::TX_DATA :
                                                   usb_tx_pkg::TX_CRC0;
              end
            end
          end
          usb_tx_pkg::TX_DATA: begin
            if (s_valid_i && ld_s_ready && (s_last_i || !s_keep_i)) begin
              state_q <= usb_tx_pkg::TX_CRC0;
            end
          end
          usb_tx_pkg::TX_CRC0: begin
            if (ld_s_ready) begin
              state_q <= usb_tx_pkg::TX_CRC1;
            end
          end
          usb_tx_pkg::TX_CRC1: begin
            if (ld_s_ready) begin
              state_q <= usb_tx_pkg::TX_LAST;
            end
          end
          usb_tx_pkg::TX_LAST, usb_tx_pkg::TX_REGW: begin
            if (ld_s_ready) begin
              state_q <= usb_tx_pkg::TX_STOP;
            end
          end
          usb_tx_pkg::TX_STOP: begin
            // Wait for stp on the bus
            if (ulpi_stp_o) begin
              state_q <= high_speed_i ? usb_tx_pkg::TX_DONE : usb_tx_pkg::TX_IDLE;
              phy_done_q <= !high_speed_i;
            end
          end
          usb_tx_pkg::TX_DONE: begin
            // EOP seen on the line
            if (line_state_i == usb_tx_pkg::LS_SE0) begin
              state_q <= usb_tx_pkg::TX_IDLE;
              usb_done_q <= 1'b1;
            end
          end
          usb_tx_pkg::TX_INIT: begin
            if (!phy_write_i && !phy_nopid_i) begin
              state_q <= usb_tx_pkg::TX_IDLE;
            end else if (ld_t_ready) begin
              state_q <= usb_tx_pkg::TX_REGW;
            end
          end
          default: begin
            state_q <= usb_tx_pkg::TX_IDLE;
          end
        endcase
      end
    end
  end

  usb_crc16 u_crc (
    .clock   (clock),
    .reset   (reset),
    .clear_i (crc_clear),
    .valid_i (crc_valid),
    .data_i  (s_data_i),
    .crc_o   (crc)
  );

  ulpi_skid_loader u_skid (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (ld_s_valid),
    .s_last_i  (ld_s_last),
    .s_data_i  (ld_s_data),
    .t_valid_i (ld_t_valid),
    .t_last_i  (ld_t_last),
    .t_data_i  (ld_t_data),
    .m_ready_i (ld_m_ready),
    .s_ready_o (ld_s_ready),
    .t_ready_o (ld_t_ready),
    .m_valid_o (ld_m_valid),
    .m_last_o  (ld_m_last),
    .m_data_o  (ld_m_data)
  );

  a_state_onehot: assert property (
    @(posedge clock) disable iff (reset) $onehot(enc_state_o)
  );

endmodule

//--- rtl/ulpi_skid_loader.sv
`timescale 1ns/1ns
module ulpi_skid_loader (
  input  logic       clock,
  input  logic       reset,
  input  logic       s_valid_i,
  input  logic       s_last_i,
  input  logic [7:0] s_data_i,
  input  logic       t_valid_i,
  input  logic       t_last_i,
  input  logic [7:0] t_data_i,
  input  logic       m_ready_i,
  output logic       s_ready_o,
  output logic       t_ready_o,
  output logic       m_valid_o,
  output logic       m_last_o,
  output logic [7:0] m_data_o
);

  // Output register, seen on the ULPI bus
  logic       m_valid_q;
  logic       m_last_q;
  logic [7:0] m_data_q;

  // Overflow register, loaded by back-pressure or directly through t
  logic       x_valid_q;
  logic       x_last_q;
  logic [7:0] x_data_q;

  logic out_free;
  logic flush;

  // Output can take a new byte this cycle
  assign out_free = !m_valid_q || m_ready_i;

  // stp is on the bus for one cycle, then both slots empty
  assign flush = m_valid_q && m_last_q;

  assign s_ready_o = !x_valid_q;
  // Direct load needs s to go straight to the output
  assign t_ready_o = !x_valid_q && out_free;

  assign m_valid_o = m_valid_q;
  assign m_last_o = m_last_q;
  assign m_data_o = m_data_q;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      m_valid_q <= 1'b0;
      m_last_q <= 1'b0;
      x_valid_q <= 1'b0;
      x_last_q <= 1'b0;
    end else if (out_free) begin
      if (x_valid_q) begin
        // Drain the overflow slot first
        m_valid_q <= 1'b1;
        m_last_q <= x_last_q;
        x_valid_q <= 1'b0;
        x_last_q <= 1'b0;
      end else begin
        // s to the output, t behind it
        m_valid_q <= s_valid_i;
        m_last_q <= s_valid_i && s_last_i;
        x_valid_q <= t_valid_i;
        x_last_q <= t_valid_i && t_last_i;
      end
    end else if (s_valid_i && !x_valid_q) begin
      // Output stalled, park s
      x_valid_q <= 1'b1;
      x_last_q <= s_last_i;
    end
  end

  // Payload follows the same paths, valid bits qualify it
  always_ff @(posedge clock) begin
    if (out_free) begin
      m_data_q <= x_valid_q ? x_data_q : s_data_i;
    end
    if (!x_valid_q) begin
      x_data_q <= out_free ? t_data_i : s_data_i;
    end
  end

  // PHY sees a held byte until nxt
  a_hold_while_stalled: assert property (
    @(posedge clock) disable iff (reset)
    m_valid_o && !m_ready_i |=> $stable(m_data_o)
  );

endmodule

//--- rtl/usb_crc16.sv
`timescale 1ns/1ns
module usb_crc16 (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear_i,
  input  logic        valid_i,
  input  logic [7:0]  data_i,
  output logic [15:0] crc_o
);

  // Running residue, MSB-first form
  logic [15:0] crc_q;

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= usb_tx_pkg::CRC16_INIT;
    end else if (valid_i) begin
      crc_q <= usb_tx_pkg::crc16_step(data_i, crc_q);
    end
  end

  // Wire order is LSB first, so reverse the bits and invert
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_o[i] = ~crc_q[15-i];
    end
  end

  // The encoder only clears while idle, never during a byte
  a_no_clear_on_byte: assert property (
    @(posedge clock) disable iff (reset) !(valid_i && clear_i)
  );

endmodule

//--- rtl/usb_tx_pkg.sv
package usb_tx_pkg;

  // Encoder FSM states, one-hot
  typedef enum logic [9:0] {
    TX_IDLE = 10'h001,
    TX_XPID = 10'h002,
    TX_DATA = 10'h004,
    TX_CRC0 = 10'h008,
    TX_CRC1 = 10'h010,
    TX_LAST = 10'h020,
    TX_DONE = 10'h040,
    TX_INIT = 10'h080,
    TX_REGW = 10'h100,
    TX_STOP = 10'h200
  } tx_state_t;

  // ULPI command prefixes, bits [7:6] of the command byte
  localparam logic [1:0] ULPI_CMD_TX = 2'b01;
  localparam logic [1:0] ULPI_CMD_REGW = 2'b10;

  // Transmit command without a PID, starts a chirp
  localparam logic [7:0] ULPI_NOPID = 8'h40;

  // USB PIDs, lower nibble only
  localparam logic [3:0] PID_ACK = 4'b0010;
  localparam logic [3:0] PID_NAK = 4'b1010;
  localparam logic [3:0] PID_DATA0 = 4'b0011;
  localparam logic [3:0] PID_DATA1 = 4'b1011;

  // Line state of an end of packet
  localparam logic [1:0] LS_SE0 = 2'b00;

  // CRC16 over x^16 + x^15 + x^2 + 1, data bits enter LSB first
  localparam logic [15:0] CRC16_INIT = 16'hffff;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  // Start-up sequence: register writes, then one NOPID, then done
  localparam int INIT_WRITES = 2;
  localparam int INIT_STEP_W = 2;
  localparam logic [INIT_STEP_W-1:0] INIT_STEP_NOPID = INIT_STEP_W'(INIT_WRITES);
  localparam logic [INIT_STEP_W-1:0] INIT_STEP_DONE = INIT_STEP_NOPID + 1'b1;

  // Fold one byte into the residue, LSB of the byte first
  function automatic logic [15:0] crc16_step(input logic [7:0] data,
                                             input logic [15:0] crc);
    logic [15:0] c;
    logic fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ CRC16_POLY;
      end
    end
    return c;
  endfunction

  // Register address of each start-up write
  function automatic logic [7:0] init_addr(input logic [INIT_STEP_W-1:0] idx);
    case (idx)
      2'd0: return 8'h04;  // Function control
      2'd1: return 8'h0a;  // OTG control
      default: return 8'h00;
    endcase
  endfunction

  // Register value of each start-up write
  function automatic logic [7:0] init_data(input logic [INIT_STEP_W-1:0] idx);
    case (idx)
      // SuspendM set, OpMode chirp, HS transceiver
      2'd0: return 8'h50;
      // DP and DM pull-downs on
      2'd1: return 8'h06;
      default: return 8'h00;
    endcase
  endfunction

endpackage
